// File: rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  // major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111
  } opcode_e;

  // funct3 fields
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101; // srl / sra by funct7
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;
  localparam logic [2:0] F3_BLT     = 3'b100;
  localparam logic [2:0] F3_BGE     = 3'b101;
  localparam logic [2:0] F3_LBU     = 3'b100;
  localparam logic [2:0] F3_SB      = 3'b000;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_JUMP} branch_e;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_e;

endpackage

`default_nettype wire

// File: bus_pkg.sv
`default_nettype none

package bus_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8; // one select per byte lane

  localparam logic [ADDR_W-1:0] RESET_VECTOR = 32'h0000_0000;

  typedef enum logic {
    WORD = 1'b0,
    BYTE = 1'b1
  } access_e;

endpackage

`default_nettype wire

// File: decoder.sv
`timescale 1ns/1ns
`default_nettype none

module decoder (
  input  logic [rv_isa_pkg::XLEN-1:0]       i_instr,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rs1,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rs2,
  output logic [rv_isa_pkg::REG_ADDR_W-1:0] o_rd,
  output logic [rv_isa_pkg::XLEN-1:0]       o_imm,
  output rv_isa_pkg::alu_op_e               o_alu_op,
  output logic                              o_alu_src_imm,
  output logic                              o_pc_src_a,
  output rv_isa_pkg::branch_e               o_branch,
  output rv_isa_pkg::wb_sel_e               o_wb_sel,
  output logic                              o_reg_write,
  output logic                              o_mem_read,
  output logic                              o_mem_write,
  output bus_pkg::access_e                  o_size,
  output logic                              o_unsigned_load
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;
  logic [rv_isa_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  rv_isa_pkg::alu_op_e arith_op;

  assign opcode    = i_instr[6:0];
  assign funct3    = i_instr[14:12];
  assign funct7_b5 = i_instr[30];

  assign o_rs1 = i_instr[19:15];
  assign o_rs2 = i_instr[24:20];
  assign o_rd  = i_instr[11:7];

  // immediates, all sign extended from bit 31
  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  // shared by OP and OP_IMM, sub only exists in register form
  always_comb begin
    case (funct3)
      rv_isa_pkg::F3_ADD_SUB: arith_op = (opcode == rv_isa_pkg::OPC_OP && funct7_b5) ?
                                         rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     arith_op = rv_isa_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     arith_op = rv_isa_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    arith_op = rv_isa_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     arith_op = rv_isa_pkg::ALU_XOR;
      rv_isa_pkg::F3_SR:      arith_op = funct7_b5 ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      arith_op = rv_isa_pkg::ALU_OR;
      default:                arith_op = rv_isa_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    // defaults give a no-op
    o_imm           = imm_i;
    o_alu_op        = rv_isa_pkg::ALU_ADD;
    o_alu_src_imm   = 1'b0;
    o_pc_src_a      = 1'b0;
    o_branch        = rv_isa_pkg::BR_NONE;
    o_wb_sel        = rv_isa_pkg::WB_ALU;
    o_reg_write     = 1'b0;
    o_mem_read      = 1'b0;
    o_mem_write     = 1'b0;
    o_size          = bus_pkg::WORD;
    o_unsigned_load = 1'b0;
    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        o_alu_op    = arith_op;
        o_reg_write = 1'b1;
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        o_alu_op      = arith_op;
        o_alu_src_imm = 1'b1;
        o_reg_write   = 1'b1;
      end
      rv_isa_pkg::OPC_LUI: begin
        o_imm         = imm_u;
        o_alu_op      = rv_isa_pkg::ALU_PASS_B;
        o_alu_src_imm = 1'b1;
        o_reg_write   = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        o_imm         = imm_u;
        o_alu_src_imm = 1'b1;
        o_pc_src_a    = 1'b1; // pc + upper immediate
        o_reg_write   = 1'b1;
      end
      rv_isa_pkg::OPC_LOAD: begin
        o_alu_src_imm   = 1'b1;
        o_mem_read      = 1'b1;
        o_reg_write     = 1'b1;
        o_wb_sel        = rv_isa_pkg::WB_MEM;
        o_size          = (funct3 == rv_isa_pkg::F3_LBU) ? bus_pkg::BYTE : bus_pkg::WORD;
        o_unsigned_load = funct3[2];
      end
      rv_isa_pkg::OPC_STORE: begin
        o_imm         = imm_s;
        o_alu_src_imm = 1'b1;
        o_mem_write   = 1'b1;
        o_size        = (funct3 == rv_isa_pkg::F3_SB) ? bus_pkg::BYTE : bus_pkg::WORD;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        o_imm    = imm_b;
        o_alu_op = rv_isa_pkg::ALU_SUB; // compare uses rs1 - rs2
        case (funct3)
          rv_isa_pkg::F3_BEQ: o_branch = rv_isa_pkg::BR_EQ;
          rv_isa_pkg::F3_BNE: o_branch = rv_isa_pkg::BR_NE;
          rv_isa_pkg::F3_BLT: o_branch = rv_isa_pkg::BR_LT;
          rv_isa_pkg::F3_BGE: o_branch = rv_isa_pkg::BR_GE;
          default:            o_branch = rv_isa_pkg::BR_NONE;
        endcase
      end
      rv_isa_pkg::OPC_JAL: begin
        o_imm       = imm_j;
        o_pc_src_a  = 1'b1;
        o_branch    = rv_isa_pkg::BR_JUMP;
        o_wb_sel    = rv_isa_pkg::WB_PC4;
        o_reg_write = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        o_branch    = rv_isa_pkg::BR_JUMP; // rs1 based target
        o_wb_sel    = rv_isa_pkg::WB_PC4;
        o_reg_write = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: register_file.sv
`timescale 1ns/1ns
`default_nettype none

module register_file (
  input  logic                              i_clock,
  input  logic                              i_rst,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rs1,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rs2,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] i_rd,
  input  logic                              i_we,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_wd,
  output logic [rv_isa_pkg::XLEN-1:0]       o_rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]       o_rs2_data
);

  logic [rv_isa_pkg::XLEN-1:0] regs [rv_isa_pkg::NUM_REGS];

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      for (int i = 0; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin // x0 never written
      regs[i_rd] <= i_wd;
    end
  end

  // async read ports
  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

endmodule

`default_nettype wire

// File: execute_unit.sv
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
  input  logic [rv_isa_pkg::XLEN-1:0] i_pc,
  input  logic [rv_isa_pkg::XLEN-1:0] i_rs1_data,
  input  logic [rv_isa_pkg::XLEN-1:0] i_rs2_data,
  input  logic [rv_isa_pkg::XLEN-1:0] i_imm,
  input  rv_isa_pkg::alu_op_e         i_alu_op,
  input  logic                        i_alu_src_imm,
  input  logic                        i_pc_src_a,
  input  rv_isa_pkg::branch_e         i_branch,
  output logic [rv_isa_pkg::XLEN-1:0] o_result,
  output logic                        o_take_branch,
  output logic [rv_isa_pkg::XLEN-1:0] o_target
);

  localparam int SHAMT_W = $clog2(rv_isa_pkg::XLEN);

  logic [rv_isa_pkg::XLEN-1:0] op_a, op_b, diff;
  logic [rv_isa_pkg::XLEN:0]   sub_ext; // extra bit is the borrow
  logic [SHAMT_W-1:0]          shamt;
  logic                        lt_signed, lt_unsigned;

  assign op_a  = i_pc_src_a ? i_pc : i_rs1_data;
  assign op_b  = i_alu_src_imm ? i_imm : i_rs2_data;
  assign shamt = op_b[SHAMT_W-1:0];

  assign sub_ext     = {1'b0, op_a} - {1'b0, op_b};
  assign diff        = sub_ext[rv_isa_pkg::XLEN-1:0];
  assign lt_unsigned = sub_ext[rv_isa_pkg::XLEN];
  // signs differ means a is less when a is negative
  assign lt_signed   = (op_a[rv_isa_pkg::XLEN-1] != op_b[rv_isa_pkg::XLEN-1]) ?
                       op_a[rv_isa_pkg::XLEN-1] : diff[rv_isa_pkg::XLEN-1];

  always_comb begin
    case (i_alu_op)
      rv_isa_pkg::ALU_SUB:    o_result = diff;
      rv_isa_pkg::ALU_AND:    o_result = op_a & op_b;
      rv_isa_pkg::ALU_OR:     o_result = op_a | op_b;
      rv_isa_pkg::ALU_XOR:    o_result = op_a ^ op_b;
      rv_isa_pkg::ALU_SLT:    o_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_signed};
      rv_isa_pkg::ALU_SLTU:   o_result = {{(rv_isa_pkg::XLEN-1){1'b0}}, lt_unsigned};
      rv_isa_pkg::ALU_SLL:    o_result = op_a << shamt;
      rv_isa_pkg::ALU_SRL:    o_result = op_a >> shamt;
      rv_isa_pkg::ALU_SRA:    o_result = $signed(op_a) >>> shamt;
      rv_isa_pkg::ALU_PASS_B: o_result = op_b;
      default:                o_result = op_a + op_b;
    endcase
  end

  always_comb begin
    case (i_branch)
      rv_isa_pkg::BR_EQ:   o_take_branch = (diff == '0);
      rv_isa_pkg::BR_NE:   o_take_branch = (diff != '0);
      rv_isa_pkg::BR_LT:   o_take_branch = lt_signed;
      rv_isa_pkg::BR_GE:   o_take_branch = !lt_signed;
      rv_isa_pkg::BR_JUMP: o_take_branch = 1'b1;
      default:             o_take_branch = 1'b0;
    endcase
  end

  // jalr is a jump that does not take pc as operand a
  always_comb begin
    if (i_branch == rv_isa_pkg::BR_JUMP && !i_pc_src_a) begin
      o_target = (i_rs1_data + i_imm) & ~{{(rv_isa_pkg::XLEN-1){1'b0}}, 1'b1};
    end else begin
      o_target = i_pc + i_imm;
    end
  end

endmodule

`default_nettype wire

// File: request_unit.sv
`timescale 1ns/1ns
`default_nettype none

module request_unit (
  input  logic                        i_clock,
  input  logic                        i_rst,
  input  logic [bus_pkg::ADDR_W-1:0]  i_pc,
  input  logic                        i_mem_read,
  input  logic                        i_mem_write,
  input  logic [bus_pkg::ADDR_W-1:0]  i_data_adr,
  input  logic [bus_pkg::DATA_W-1:0]  i_store_data,
  input  bus_pkg::access_e            i_size,
  input  logic [bus_pkg::DATA_W-1:0]  i_dat_r,
  input  logic                        i_busy,
  output logic                        o_read,
  output logic                        o_write,
  output logic [bus_pkg::ADDR_W-1:0]  o_adr,
  output logic [bus_pkg::SEL_W-1:0]   o_sel,
  output logic [bus_pkg::DATA_W-1:0]  o_dat_w,
  output logic [bus_pkg::DATA_W-1:0]  o_instr,
  output logic                        o_instr_valid,
  output logic [bus_pkg::DATA_W-1:0]  o_data_read,
  output logic                        o_d_done,
  output logic                        o_commit
);

  typedef enum logic [1:0] {FETCH, EXEC, MEM} state_e;

  state_e state, state_next;
  logic   mem_access;
  logic   fetch_done;
  logic [bus_pkg::DATA_W-1:0] instr_q;

  assign mem_access = i_mem_read || i_mem_write;
  assign fetch_done = (state == FETCH) && !i_busy;
  assign o_d_done   = (state == MEM) && !i_busy;

  always_comb begin
    state_next = state;
    case (state)
      FETCH:   if (fetch_done) state_next = EXEC;
      EXEC:    state_next = mem_access ? MEM : FETCH;
      MEM:     if (o_d_done) state_next = FETCH;
      default: state_next = FETCH;
    endcase
  end

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      state <= FETCH;
    end else begin
      state <= state_next;
    end
  end

  // instruction held until the next fetch completes
  always_ff @(posedge i_clock) begin
    if (fetch_done) begin
      instr_q <= i_dat_r;
    end
  end

  assign o_instr       = instr_q;
  assign o_instr_valid = (state != FETCH);
  assign o_data_read   = i_dat_r; // sampled by core on o_d_done

  // strobes follow the state, so they drop the cycle after completion
  assign o_read  = (state == FETCH) || (state == MEM && i_mem_read);
  assign o_write = (state == MEM) && i_mem_write;
  assign o_adr   = (state == MEM) ? i_data_adr : i_pc;
  assign o_dat_w = i_store_data;

  always_comb begin
    if (state == MEM && i_size == bus_pkg::BYTE) begin
      o_sel = bus_pkg::SEL_W'(1) << i_data_adr[1:0]; // one lane per byte address
    end else begin
      o_sel = '1;
    end
  end

  assign o_commit = ((state == EXEC) && !mem_access) || o_d_done;

  a_one_strobe: assert property (@(posedge i_clock) disable iff (i_rst)
    !(o_read && o_write));

  // a stalled request keeps its address and selects until it completes
  a_stable_while_busy: assert property (@(posedge i_clock) disable iff (i_rst)
    (o_read || o_write) && i_busy |=> $stable(o_adr) && $stable(o_sel) &&
    (o_read || o_write));

endmodule

`default_nettype wire

// File: core.sv
`timescale 1ns/1ns
`default_nettype none

module core (
  input  logic                       i_clock,
  input  logic                       i_rst,
  input  logic [bus_pkg::DATA_W-1:0] i_dat_r,
  input  logic                       i_busy,
  output logic                       o_read,
  output logic                       o_write,
  output logic [bus_pkg::ADDR_W-1:0] o_adr,
  output logic [bus_pkg::SEL_W-1:0]  o_sel,
  output logic [bus_pkg::DATA_W-1:0] o_dat_w
);

  logic [rv_isa_pkg::XLEN-1:0]       pc, pc_plus4;
  logic [bus_pkg::DATA_W-1:0]        instr, data_read, store_data;
  logic                              instr_valid, d_done, commit;
  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1, rs2, rd;
  logic [rv_isa_pkg::XLEN-1:0]       imm, rs1_data, rs2_data, result, target;
  logic [rv_isa_pkg::XLEN-1:0]       wd, load_value;
  logic [7:0]                        load_byte;
  rv_isa_pkg::alu_op_e               alu_op;
  rv_isa_pkg::branch_e               branch;
  rv_isa_pkg::wb_sel_e               wb_sel;
  bus_pkg::access_e                  size;
  logic alu_src_imm, pc_src_a, reg_write, mem_read, mem_write, unsigned_load;
  logic take_branch, register_file_en;

  request_unit ru (
    .i_clock(i_clock), .i_rst(i_rst), .i_pc(pc),
    .i_mem_read(mem_read && instr_valid), .i_mem_write(mem_write && instr_valid),
    .i_data_adr(result), .i_store_data(store_data), .i_size(size),
    .i_dat_r(i_dat_r), .i_busy(i_busy),
    .o_read(o_read), .o_write(o_write), .o_adr(o_adr), .o_sel(o_sel), .o_dat_w(o_dat_w),
    .o_instr(instr), .o_instr_valid(instr_valid), .o_data_read(data_read),
    .o_d_done(d_done), .o_commit(commit)
  );

  decoder dec (
    .i_instr(instr), .o_rs1(rs1), .o_rs2(rs2), .o_rd(rd), .o_imm(imm),
    .o_alu_op(alu_op), .o_alu_src_imm(alu_src_imm), .o_pc_src_a(pc_src_a),
    .o_branch(branch), .o_wb_sel(wb_sel), .o_reg_write(reg_write),
    .o_mem_read(mem_read), .o_mem_write(mem_write), .o_size(size),
    .o_unsigned_load(unsigned_load)
  );

  register_file rf (
    .i_clock(i_clock), .i_rst(i_rst), .i_rs1(rs1), .i_rs2(rs2), .i_rd(rd),
    .i_we(register_file_en), .i_wd(wd), .o_rs1_data(rs1_data), .o_rs2_data(rs2_data)
  );

  execute_unit ex (
    .i_pc(pc), .i_rs1_data(rs1_data), .i_rs2_data(rs2_data), .i_imm(imm),
    .i_alu_op(alu_op), .i_alu_src_imm(alu_src_imm), .i_pc_src_a(pc_src_a),
    .i_branch(branch), .o_result(result), .o_take_branch(take_branch), .o_target(target)
  );

  assign pc_plus4 = pc + 32'd4;

  always_ff @(posedge i_clock) begin
    if (i_rst) begin
      pc <= bus_pkg::RESET_VECTOR;
    end else if (commit) begin
      pc <= take_branch ? target : pc_plus4;
    end
  end

  // byte loads pick their lane, then extend
  assign load_byte  = data_read[{result[1:0], 3'b000} +: 8];
  assign load_value = (size == bus_pkg::BYTE) ?
                      {{24{load_byte[7] && !unsigned_load}}, load_byte} : data_read;

  always_comb begin
    case (wb_sel)
      rv_isa_pkg::WB_MEM: wd = load_value;
      rv_isa_pkg::WB_PC4: wd = pc_plus4;
      default:            wd = result;
    endcase
  end

  // sb drives the byte on every lane, o_sel picks one
  assign store_data = (size == bus_pkg::BYTE) ? {4{rs2_data[7:0]}} : rs2_data;

  // loads write back only once the data beat is in
  always_comb begin
    register_file_en = 1'b0;
    if (reg_write && instr_valid) begin
      if (mem_read) begin
        register_file_en = d_done;
      end else begin
        register_file_en = commit;
      end
    end
  end

  a_pc_aligned: assert property (@(posedge i_clock) disable iff (i_rst)
    commit |=> pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: tb_core.sv
`timescale 1ns/1ns
`default_nettype none

module tb_core;

  localparam int MEM_WORDS   = 256;
  localparam int REC_BASE    = 256; // store count, then address/data/sel triples
  localparam int RUN_LIMIT   = 4000;
  localparam int LOOP_LIMIT  = 200;
  localparam int FETCH_LIMIT = 10;

  logic                       clock;
  logic                       rst;
  logic [bus_pkg::DATA_W-1:0] bus_dat_r;
  logic                       bus_busy;
  logic                       bus_read;
  logic                       bus_write;
  logic [bus_pkg::ADDR_W-1:0] bus_adr;
  logic [bus_pkg::SEL_W-1:0]  bus_sel;
  logic [bus_pkg::DATA_W-1:0] bus_dat_w;

  logic [31:0] mem [MEM_WORDS];
  logic [31:0] patterns [2*MEM_WORDS];
  integer      seed = 58698;
  int          rec_count;
  int          rec_idx;
  int          busy_left;
  logic        req_open;  // current request already got its busy count
  logic        prev_read;
  logic        prev_write;
  logic [31:0] prev_adr;
  logic [31:0] prev_dat;
  logic [3:0]  prev_sel;
  logic [31:0] last_read;
  logic        last_read_ok;
  logic        loop_seen;

  core dut (
    .i_clock(clock), .i_rst(rst), .i_dat_r(bus_dat_r), .i_busy(bus_busy),
    .o_read(bus_read), .o_write(bus_write), .o_adr(bus_adr), .o_sel(bus_sel),
    .o_dat_w(bus_dat_w)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("** Error %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  // compare a finished write with the next record, then apply it
  task automatic record_store(input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
    int base;
    base = REC_BASE + 1 + 3 * rec_idx;
    if (rec_idx >= rec_count) begin
      abort_run($sformatf("unexpected write to %h after the last expected store", adr));
    end else begin
      check_value($sformatf("store %0d address", rec_idx), patterns[base], adr);
      check_value($sformatf("store %0d data", rec_idx), patterns[base + 1], dat);
      check_value($sformatf("store %0d sel", rec_idx), patterns[base + 2], {28'b0, sel});
      for (int b = 0; b < 4; b++) begin
        if (sel[b]) mem[adr[9:2]][8*b +: 8] = dat[8*b +: 8];
      end
      rec_idx++;
    end
  endtask

  // two reads in a row from one address only happen in the final self-loop
  task automatic note_read(input logic [31:0] adr);
    if (last_read_ok && adr == last_read) loop_seen = 1'b1;
    last_read    = adr;
    last_read_ok = 1'b1;
  endtask

  // transfer done on the rising edge with strobe up and busy low
  always @(negedge clock) begin
    if (!rst && (prev_read || prev_write) && !bus_busy) begin
      if (prev_write) begin
        record_store(prev_adr, prev_dat, prev_sel);
      end else begin
        note_read(prev_adr);
      end
      req_open = 1'b0;
    end
    prev_read  = bus_read;
    prev_write = bus_write;
    prev_adr   = bus_adr;
    prev_dat   = bus_dat_w;
    prev_sel   = bus_sel;
    if (rst) begin
      req_open  = 1'b0;
      busy_left = 0;
      bus_busy <= 1'b0;
    end else if (bus_read || bus_write) begin
      if (!req_open) begin
        busy_left = $unsigned($random(seed)) % 4; // 0 to 3 stall cycles
        req_open  = 1'b1;
      end
      bus_busy <= (busy_left != 0);
      if (busy_left != 0) busy_left--;
    end else begin
      bus_busy <= 1'b0;
    end
    bus_dat_r <= mem[bus_adr[9:2]];
  end

  initial begin
    int cycles;
    rst          = 1'b1;
    bus_busy     = 1'b0;
    bus_dat_r    = '0;
    rec_idx      = 0;
    busy_left    = 0;
    req_open     = 1'b0;
    prev_read    = 1'b0;
    prev_write   = 1'b0;
    last_read_ok = 1'b0;
    loop_seen    = 1'b0;
    for (int i = 0; i < 2*MEM_WORDS; i++) begin
      patterns[i] = 32'h5a00_0000 ^ i;
    end
    $readmemh("core_patterns.mem", patterns);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = patterns[i];
    end
    rec_count = patterns[REC_BASE];

    repeat (3) begin
      @(negedge clock);
      check_value("write strobe during reset", 32'd0, {31'b0, bus_write});
    end
    rst <= 1'b0;
    cycles = 0;
    while (!bus_read) begin
      @(negedge clock);
      cycles++;
      if (cycles > FETCH_LIMIT) abort_run("no instruction fetch after reset");
    end
    check_value("first fetch address", 32'h0000_0000, bus_adr);

    cycles = 0;
    while (rec_idx < rec_count) begin
      @(posedge clock);
      cycles++;
      if (cycles > RUN_LIMIT) begin
        abort_run($sformatf("timed out with %0d of %0d stores seen", rec_idx, rec_count));
      end
    end
    cycles = 0;
    while (!loop_seen) begin
      @(posedge clock);
      cycles++;
      if (cycles > LOOP_LIMIT) abort_run("program never reached its final self-loop");
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: core_patterns.mem
// program words from address 0, six per line, byte address of the first in the note
// at word 0x100 the store count, then one store per line: address data byte-selects
@000
30000093 FFB00113 00C00193 00310233 0040A023 403102B3 // 0x00 setup, add, sub
0050A223 00312333 003133B3 00314433 0060A423 0070A623 // 0x18 slt, sltu, xor
0080A823 40115493 00315533 003195B3 0090AA23 00A0AC23 // 0x30 shifts
00B0AE23 0F017613 1001E693 12345737 00001797 02C0A023 // 0x48 andi, ori, lui, auipc
02D0A223 02E0A423 02F0A623 0000A803 00180813 0300A823 // 0x60 lw
0050C883 0310AA23 02808B23 0340A903 0320AC23 00218463 // 0x78 lbu, sb, beq
0230AE23 00219463 0420A023 00314463 0420A023 00315463 // 0x90 bne, blt, bge
00C009EF 0420A023 0420A023 0530A023 0C800A13 001A0AE7 // 0xa8 jal, jalr
0420A023 0420A023 0550A223 00500013 0400A423 0000006F // 0xc0 x0 write, self-loop
@100
00000014
00000300 00000007 0000000F
00000304 FFFFFFEF 0000000F
00000308 00000001 0000000F
0000030C 00000000 0000000F
00000310 FFFFFFF7 0000000F
00000314 FFFFFFFD 0000000F
00000318 000FFFFF 0000000F
0000031C 0000C000 0000000F
00000320 000000F0 0000000F
00000324 0000010C 0000000F
00000328 12345000 0000000F
0000032C 00001058 0000000F
00000330 00000008 0000000F
00000334 000000FF 0000000F
00000336 F7F7F7F7 00000004
00000338 00F700FF 0000000F
0000033C 0000000C 0000000F
00000340 000000AC 0000000F
00000344 000000C0 0000000F
00000348 00000000 0000000F

// File: tb.f
rv_isa_pkg.sv
bus_pkg.sv
decoder.sv
register_file.sv
execute_unit.sv
request_unit.sv
core.sv
tb_core.sv
